/* include/r5_defines.svh */
/* global widths, memory size and reset vector of the r5 core
   include wherever one of these values is needed */

`ifndef R5_DEFINES_SVH
`define R5_DEFINES_SVH

// register and data path width
`define R5_XLEN 32

// byte enables per bus word
`define R5_BW 4

// default memory size in bytes
`define R5_MEM_SZ 4096

// first fetch address after reset
`define R5_RESET_PC 32'h0000_0000

`endif

/* rtl/r5_isa_pkg.sv */
/* instruction level types of the r5 core: opcodes, ALU operations,
   the fetched word viewed as I or S/B layout, and the decoded control word */

`include "r5_defines.svh"

package r5_isa_pkg;

  ////////////////////////////////////////////////////////////////////////////
  // major opcodes
  ////////////////////////////////////////////////////////////////////////////

  // only the opcodes that the core runs
  typedef enum logic [6:0] {
    OP_LUI    = 7'b0110111,
    OP_JAL    = 7'b1101111,
    OP_BRANCH = 7'b1100011,
    OP_LOAD   = 7'b0000011,
    OP_STORE  = 7'b0100011,
    OP_IMM    = 7'b0010011,
    OP_REG    = 7'b0110011,
    OP_SYSTEM = 7'b1110011
  } op_e;

  // ALU operations
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_XOR,
    ALU_OR,
    ALU_AND,
    ALU_SLT,
    // immediate straight through, for lui
    ALU_PASS_B
  } alu_e;

  ////////////////////////////////////////////////////////////////////////////
  // instruction word layouts
  ////////////////////////////////////////////////////////////////////////////

  // I layout, also carries the U and J immediate bits
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    op_e         opcode;
  } i_t;

  // S and B layout, split immediate around rs2/rs1
  typedef struct packed {
    logic [6:0] imm_hi;
    logic [4:0] rs2;
    logic [4:0] rs1;
    logic [2:0] funct3;
    logic [4:0] imm_lo;
    op_e        opcode;
  } s_t;

  // one fetched word, decoded through both views
  typedef union packed {
    i_t i;
    s_t s;
  } inst_u;

  ////////////////////////////////////////////////////////////////////////////
  // decoded control word
  ////////////////////////////////////////////////////////////////////////////

  typedef struct packed {
    logic [4:0]          rs1;
    logic [4:0]          rs2;
    logic [4:0]          rd;
    logic [`R5_XLEN-1:0] imm;
    alu_e                alu_op;
    logic                use_imm;
    logic                is_load;
    logic                is_store;
    logic                is_branch;
    logic                branch_ne;
    logic                is_jal;
    logic                is_halt;
    logic                wb_en;
  } ctl_t;

endpackage

/* rtl/r5_bus_pkg.sv */
/* memory bus request/response structs and the retire trace record
   shared by the core stages, the memory model and the testbench */

`include "r5_defines.svh"

package r5_bus_pkg;

  // request, accepted in the cycle vld is high
  typedef struct packed {
    logic                vld;
    logic                wen;
    logic [31:0]         adr;
    logic [`R5_BW-1:0]   ben;
    logic [`R5_XLEN-1:0] wdt;
  } bus_req_t;

  // response, rdt valid one cycle after a read request
  typedef struct packed {
    logic                rdy;
    logic [`R5_XLEN-1:0] rdt;
  } bus_rsp_t;

  // one record per completed instruction
  typedef struct packed {
    logic                vld;
    logic [31:0]         pc;
    logic [4:0]          rd;
    // value written, 0 if nothing written
    logic [`R5_XLEN-1:0] wdt;
  } retire_t;

endpackage

/* rtl/r5_mem.sv */
/* byte array memory model with a read-only fetch port, a load/store port
   and a write-only loader port; one cycle reads, rdy always high */

`timescale 1ns/1ps
`include "r5_defines.svh"

module r5_mem #(
  // size in bytes
  parameter int unsigned SZ = `R5_MEM_SZ
)(
  input  logic                 bus_if,
  input  r5_bus_pkg::bus_req_t fetch_req,
  output r5_bus_pkg::bus_rsp_t fetch_rsp,
  input  r5_bus_pkg::bus_req_t ls_req,
  output r5_bus_pkg::bus_rsp_t ls_rsp,
  input  r5_bus_pkg::bus_req_t ldr_req
);

  localparam int unsigned AW = $clog2(SZ);

  logic [7:0] mem [0:SZ-1];

  logic [`R5_XLEN-1:0] fetch_rdt;
  logic [`R5_XLEN-1:0] ls_rdt;

  // write ports, later index wins on the same byte
  r5_bus_pkg::bus_req_t wr_port [2];

  assign wr_port[0] = ls_req;
  assign wr_port[1] = ldr_req;

  // lanes with ben low read back as x
  function automatic logic [`R5_XLEN-1:0] rd_word(input r5_bus_pkg::bus_req_t req);
    logic [`R5_XLEN-1:0] w;
    for (int b = 0; b < `R5_BW; b++) begin
      if (req.ben[b]) begin
        w[8*b +: 8] = mem[req.adr[AW-1:0] + AW'(b)];
      end else begin
        w[8*b +: 8] = 'x;
      end
    end
    return w;
  endfunction

  ////////////////////////////////////////////////////////////////////////////
  // writes
  ////////////////////////////////////////////////////////////////////////////

  // loader after load/store, so the loader wins a collision
  always_ff @(posedge bus_if) begin
    for (int p = 0; p < 2; p++) begin
      if (wr_port[p].vld && wr_port[p].wen) begin
        for (int b = 0; b < `R5_BW; b++) begin
          if (wr_port[p].ben[b]) begin
            mem[wr_port[p].adr[AW-1:0] + AW'(b)] <= wr_port[p].wdt[8*b +: 8];
          end
        end
      end
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // reads
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus_if) begin
    // fetch port never writes
    if (fetch_req.vld) begin
      fetch_rdt <= rd_word(fetch_req);
    end
    if (ls_req.vld && !ls_req.wen) begin
      ls_rdt <= rd_word(ls_req);
    end
  end

  // trivial ready
  assign fetch_rsp.rdy = 1'b1;
  assign fetch_rsp.rdt = fetch_rdt;
  assign ls_rsp.rdy    = 1'b1;
  assign ls_rsp.rdt    = ls_rdt;

endmodule

/* rtl/r5_decode.sv */
/* pc, fetch sequencing and instruction decode of the r5 core
   issues one fetch per instruction and waits for done from the result stage */

`timescale 1ns/1ps
`include "r5_defines.svh"

module r5_decode (
  input  logic                 bus_if,
  input  logic                 rst,
  output r5_bus_pkg::bus_req_t fetch_req,
  input  r5_bus_pkg::bus_rsp_t fetch_rsp,
  input  logic [31:0]          next_pc,
  input  logic                 done,
  output logic                 dec_vld,
  output r5_isa_pkg::ctl_t     dec_ctl,
  output logic [31:0]          dec_pc,
  output logic                 halted
);

  // idle after reset or halt, wait while fetching, busy until done
  localparam logic [1:0] ST_IDLE = 2'd0;
  localparam logic [1:0] ST_WAIT = 2'd1;
  localparam logic [1:0] ST_BUSY = 2'd2;

  logic [1:0]  state;
  logic [31:0] pc;
  // current instruction is ebreak
  logic        cur_halt;

  r5_isa_pkg::inst_u   inst;
  logic [`R5_XLEN-1:0] imm_i;
  logic [`R5_XLEN-1:0] imm_s;
  logic [`R5_XLEN-1:0] imm_b;
  logic [`R5_XLEN-1:0] imm_u;
  logic [`R5_XLEN-1:0] imm_j;

  ////////////////////////////////////////////////////////////////////////////
  // fetch sequencing
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus_if) begin
    if (rst) begin
      state    <= ST_IDLE;
      pc       <= `R5_RESET_PC;
      dec_vld  <= 1'b0;
      cur_halt <= 1'b0;
      halted   <= 1'b0;
    end else begin
      // word arrives the cycle after the fetch
      dec_vld <= (state == ST_WAIT);
      if (dec_vld) begin
        cur_halt <= dec_ctl.is_halt;
      end
      case (state)
        ST_IDLE: begin
          if (!halted) begin
            state <= ST_WAIT;
          end
        end
        ST_WAIT: begin
          state <= ST_BUSY;
        end
        ST_BUSY: begin
          if (done) begin
            pc <= next_pc;
            // stop for good after ebreak
            if (cur_halt) begin
              halted <= 1'b1;
              state  <= ST_IDLE;
            end else begin
              state <= ST_WAIT;
            end
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  // one-cycle fetch of a full word
  always_comb begin
    fetch_req     = '0;
    fetch_req.vld = (state == ST_WAIT);
    fetch_req.adr = pc;
    fetch_req.ben = '1;
  end

  assign dec_pc = pc;

  ////////////////////////////////////////////////////////////////////////////
  // decode
  ////////////////////////////////////////////////////////////////////////////

  assign inst = fetch_rsp.rdt;

  // immediates, from both union views
  assign imm_i = {{20{inst.i.imm[11]}}, inst.i.imm};
  assign imm_s = {{20{inst.s.imm_hi[6]}}, inst.s.imm_hi, inst.s.imm_lo};
  assign imm_b = {{19{inst.s.imm_hi[6]}}, inst.s.imm_hi[6], inst.s.imm_lo[0],
                  inst.s.imm_hi[5:0], inst.s.imm_lo[4:1], 1'b0};
  assign imm_u = {inst.i.imm, inst.i.rs1, inst.i.funct3, 12'h000};
  // j immediate bits sit in the upper 20 bits of the i view
  assign imm_j = {{11{inst.i.imm[11]}}, inst.i.imm[11], inst.i.rs1, inst.i.funct3,
                  inst.i.imm[0], inst.i.imm[10:1], 1'b0};

  // funct3 to alu op, sub only from the register form
  function automatic r5_isa_pkg::alu_e f3_alu(input logic [2:0] f3, input logic sub);
    case (f3)
      3'b000: return sub ? r5_isa_pkg::ALU_SUB : r5_isa_pkg::ALU_ADD;
      3'b010: return r5_isa_pkg::ALU_SLT;
      3'b100: return r5_isa_pkg::ALU_XOR;
      3'b110: return r5_isa_pkg::ALU_OR;
      3'b111: return r5_isa_pkg::ALU_AND;
      default: return r5_isa_pkg::ALU_ADD;
    endcase
  endfunction

  always_comb begin
    dec_ctl        = '0;
    dec_ctl.rs1    = inst.i.rs1;
    dec_ctl.rs2    = inst.s.rs2;
    dec_ctl.rd     = inst.i.rd;
    dec_ctl.alu_op = r5_isa_pkg::ALU_ADD;
    case (inst.i.opcode)
      r5_isa_pkg::OP_LUI: begin
        dec_ctl.imm     = imm_u;
        dec_ctl.alu_op  = r5_isa_pkg::ALU_PASS_B;
        dec_ctl.use_imm = 1'b1;
        dec_ctl.wb_en   = 1'b1;
      end
      r5_isa_pkg::OP_IMM: begin
        dec_ctl.imm     = imm_i;
        dec_ctl.alu_op  = f3_alu(inst.i.funct3, 1'b0);
        dec_ctl.use_imm = 1'b1;
        dec_ctl.wb_en   = 1'b1;
      end
      r5_isa_pkg::OP_REG: begin
        // funct7 bit 5 picks sub
        dec_ctl.alu_op = f3_alu(inst.i.funct3, inst.s.imm_hi[5]);
        dec_ctl.wb_en  = 1'b1;
      end
      r5_isa_pkg::OP_LOAD: begin
        dec_ctl.imm     = imm_i;
        dec_ctl.use_imm = 1'b1;
        dec_ctl.is_load = 1'b1;
        dec_ctl.wb_en   = 1'b1;
      end
      r5_isa_pkg::OP_STORE: begin
        dec_ctl.imm      = imm_s;
        dec_ctl.use_imm  = 1'b1;
        dec_ctl.is_store = 1'b1;
      end
      r5_isa_pkg::OP_BRANCH: begin
        // funct3 bit 0 set for bne
        dec_ctl.imm       = imm_b;
        dec_ctl.is_branch = 1'b1;
        dec_ctl.branch_ne = inst.i.funct3[0];
      end
      r5_isa_pkg::OP_JAL: begin
        dec_ctl.imm    = imm_j;
        dec_ctl.is_jal = 1'b1;
        dec_ctl.wb_en  = 1'b1;
      end
      r5_isa_pkg::OP_SYSTEM: dec_ctl.is_halt = 1'b1;
      // anything else retires as a nop
      default: dec_ctl.wb_en = 1'b0;
    endcase
  end

endmodule

/* rtl/r5_execute.sv */
/* register file, ALU, branch resolution and next pc of the r5 core
   takes the decoded word on dec_vld and registers its results for one cycle */

`timescale 1ns/1ps
`include "r5_defines.svh"

module r5_execute (
  input  logic                bus_if,
  input  logic                rst,
  input  logic                dec_vld,
  input  r5_isa_pkg::ctl_t    dec_ctl,
  input  logic [31:0]         dec_pc,
  output logic                exe_vld,
  output r5_isa_pkg::ctl_t    exe_ctl,
  output logic [31:0]         exe_pc,
  output logic [`R5_XLEN-1:0] exe_res,
  output logic [`R5_XLEN-1:0] exe_rs2,
  output logic [31:0]         next_pc,
  input  logic                wb_en,
  input  logic [4:0]          wb_rd,
  input  logic [`R5_XLEN-1:0] wb_dat
);

  // x0 has no storage
  logic [`R5_XLEN-1:0] rf [1:31];

  logic [`R5_XLEN-1:0] rs1_val;
  logic [`R5_XLEN-1:0] rs2_val;
  logic [`R5_XLEN-1:0] op_b;
  logic [`R5_XLEN-1:0] alu_res;
  logic [31:0]         pc_inc;
  logic [31:0]         pc_tgt;
  logic                taken;

  ////////////////////////////////////////////////////////////////////////////
  // register file
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus_if) begin
    if (rst) begin
      for (int r = 1; r < 32; r++) begin
        rf[r] <= '0;
      end
    end else if (wb_en && (wb_rd != 5'd0)) begin
      rf[wb_rd] <= wb_dat;
    end
  end

  // x0 reads zero
  assign rs1_val = (dec_ctl.rs1 == 5'd0) ? '0 : rf[dec_ctl.rs1];
  assign rs2_val = (dec_ctl.rs2 == 5'd0) ? '0 : rf[dec_ctl.rs2];

  ////////////////////////////////////////////////////////////////////////////
  // alu and branch
  ////////////////////////////////////////////////////////////////////////////

  assign op_b = dec_ctl.use_imm ? dec_ctl.imm : rs2_val;

  always_comb begin
    case (dec_ctl.alu_op)
      r5_isa_pkg::ALU_ADD:    alu_res = rs1_val + op_b;
      r5_isa_pkg::ALU_SUB:    alu_res = rs1_val - op_b;
      r5_isa_pkg::ALU_XOR:    alu_res = rs1_val ^ op_b;
      r5_isa_pkg::ALU_OR:     alu_res = rs1_val | op_b;
      r5_isa_pkg::ALU_AND:    alu_res = rs1_val & op_b;
      // signed compare
      r5_isa_pkg::ALU_SLT:    alu_res = {{(`R5_XLEN-1){1'b0}},
                                         $signed(rs1_val) < $signed(op_b)};
      r5_isa_pkg::ALU_PASS_B: alu_res = op_b;
      default:                alu_res = '0;
    endcase
  end

  // beq taken on equal, bne on not equal
  assign taken  = dec_ctl.is_branch && ((rs1_val == rs2_val) != dec_ctl.branch_ne);
  assign pc_inc = dec_pc + 32'd4;
  assign pc_tgt = dec_pc + dec_ctl.imm;

  ////////////////////////////////////////////////////////////////////////////
  // output registers
  ////////////////////////////////////////////////////////////////////////////

  always_ff @(posedge bus_if) begin
    if (rst) begin
      exe_vld <= 1'b0;
    end else begin
      exe_vld <= dec_vld;
    end
  end

  // held until the next dec_vld
  always_ff @(posedge bus_if) begin
    if (dec_vld) begin
      exe_ctl <= dec_ctl;
      exe_pc  <= dec_pc;
      // jal links pc+4
      exe_res <= dec_ctl.is_jal ? pc_inc : alu_res;
      exe_rs2 <= rs2_val;
      next_pc <= (taken || dec_ctl.is_jal) ? pc_tgt : pc_inc;
    end
  end

endmodule

/* rtl/r5_result.sv */
/* load/store access, register writeback and the retire trace of the r5 core
   non-loads complete with exe_vld, loads one cycle later */

`timescale 1ns/1ps
`include "r5_defines.svh"

module r5_result (
  input  logic                 bus_if,
  input  logic                 rst,
  input  logic                 exe_vld,
  input  r5_isa_pkg::ctl_t     exe_ctl,
  input  logic [31:0]          exe_pc,
  input  logic [`R5_XLEN-1:0]  exe_res,
  input  logic [`R5_XLEN-1:0]  exe_rs2,
  output r5_bus_pkg::bus_req_t ls_req,
  input  r5_bus_pkg::bus_rsp_t ls_rsp,
  output logic                 wb_en,
  output logic [4:0]           wb_rd,
  output logic [`R5_XLEN-1:0]  wb_dat,
  output logic                 done,
  output r5_bus_pkg::retire_t  retire
);

  // load read in flight, data lands this cycle
  logic ld_pend;

  always_ff @(posedge bus_if) begin
    if (rst) begin
      ld_pend <= 1'b0;
    end else begin
      ld_pend <= exe_vld && exe_ctl.is_load;
    end
  end

  // word access at the alu address
  always_comb begin
    ls_req     = '0;
    ls_req.vld = exe_vld && (exe_ctl.is_load || exe_ctl.is_store);
    ls_req.wen = exe_ctl.is_store;
    ls_req.adr = exe_res;
    ls_req.ben = '1;
    ls_req.wdt = exe_rs2;
  end

  // exe_ctl and exe_pc stay stable through the load cycle
  assign done   = (exe_vld && !exe_ctl.is_load) || ld_pend;
  assign wb_en  = done && exe_ctl.wb_en && (exe_ctl.rd != 5'd0);
  assign wb_rd  = exe_ctl.rd;
  assign wb_dat = ld_pend ? ls_rsp.rdt : exe_res;

  // rd and wdt read 0 when nothing is written
  always_comb begin
    retire     = '0;
    retire.vld = done;
    retire.pc  = exe_pc;
    if (wb_en) begin
      retire.rd  = wb_rd;
      retire.wdt = wb_dat;
    end
  end

endmodule

/* rtl/r5_sys.sv */
/* top level of the r5 system: decode, execute and result stages around
   the memory model; the program goes in through ldr_req while rst is high */

`timescale 1ns/1ps

module r5_sys (
  input  logic                 bus_if,
  input  logic                 rst,
  input  r5_bus_pkg::bus_req_t ldr_req,
  output r5_bus_pkg::retire_t  retire,
  output logic                 halted
);

  // memory ports
  r5_bus_pkg::bus_req_t fetch_req;
  r5_bus_pkg::bus_rsp_t fetch_rsp;
  r5_bus_pkg::bus_req_t ls_req;
  r5_bus_pkg::bus_rsp_t ls_rsp;

  // decode to execute
  logic             dec_vld;
  r5_isa_pkg::ctl_t dec_ctl;
  logic [31:0]      dec_pc;
  logic [31:0]      next_pc;

  // execute to result
  logic             exe_vld;
  r5_isa_pkg::ctl_t exe_ctl;
  logic [31:0]      exe_pc;
  logic [31:0]      exe_res;
  logic [31:0]      exe_rs2;

  // writeback and completion
  logic             wb_en;
  logic [4:0]       wb_rd;
  logic [31:0]      wb_dat;
  logic             done;

  r5_mem u_mem (
    .bus_if    (bus_if),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .ls_req    (ls_req),
    .ls_rsp    (ls_rsp),
    .ldr_req   (ldr_req)
  );

  r5_decode u_decode (
    .bus_if    (bus_if),
    .rst       (rst),
    .fetch_req (fetch_req),
    .fetch_rsp (fetch_rsp),
    .next_pc   (next_pc),
    .done      (done),
    .dec_vld   (dec_vld),
    .dec_ctl   (dec_ctl),
    .dec_pc    (dec_pc),
    .halted    (halted)
  );

  r5_execute u_execute (
    .bus_if  (bus_if),
    .rst     (rst),
    .dec_vld (dec_vld),
    .dec_ctl (dec_ctl),
    .dec_pc  (dec_pc),
    .exe_vld (exe_vld),
    .exe_ctl (exe_ctl),
    .exe_pc  (exe_pc),
    .exe_res (exe_res),
    .exe_rs2 (exe_rs2),
    .next_pc (next_pc),
    .wb_en   (wb_en),
    .wb_rd   (wb_rd),
    .wb_dat  (wb_dat)
  );

  r5_result u_result (
    .bus_if  (bus_if),
    .rst     (rst),
    .exe_vld (exe_vld),
    .exe_ctl (exe_ctl),
    .exe_pc  (exe_pc),
    .exe_res (exe_res),
    .exe_rs2 (exe_rs2),
    .ls_req  (ls_req),
    .ls_rsp  (ls_rsp),
    .wb_en   (wb_en),
    .wb_rd   (wb_rd),
    .wb_dat  (wb_dat),
    .done    (done),
    .retire  (retire)
  );

endmodule

/* tests/r5_sys_tb.sv */
/* testbench for the r5 system: loads the program from the test data file
   through the loader port during reset, then checks each retire in order */

`timescale 1ns/1ps

module r5_sys_tb;

  localparam int    CLK_PERIOD  = 100;
  localparam int    RST_CYCLES  = 8;
  // quiet cycles watched after the halt
  localparam int    TAIL_CYCLES = 16;
  localparam string DATA_FILE   = "tests/r5_testdata.txt";

  logic                 bus_if;
  logic                 rst;
  r5_bus_pkg::bus_req_t ldr_req;
  r5_bus_pkg::retire_t  retire;
  logic                 halted;

  // program image, address and word
  logic [31:0] img_adr [$];
  logic [31:0] img_wrd [$];

  // expected retire sequence
  logic [31:0] exp_pc  [$];
  logic [4:0]  exp_rd  [$];
  logic [31:0] exp_wdt [$];

  // wrong values
  int mismatch_cnt;
  // hangs, stray or missing retires
  int other_cnt;
  int ret_cnt;
  // rst released, watchdog armed
  bit run_started;

  r5_sys u_dut (
    .bus_if  (bus_if),
    .rst     (rst),
    .ldr_req (ldr_req),
    .retire  (retire),
    .halted  (halted)
  );

  initial begin
    bus_if = 1'b0;
    forever #(CLK_PERIOD / 2) bus_if = ~bus_if;
  end

  ////////////////////////////////////////////////////////////////////////////
  // test data and loader
  ////////////////////////////////////////////////////////////////////////////

  // L and R records, anything else is a comment
  task automatic read_testdata(output bit ok);
    int              fd;
    int              code;
    logic [8*80-1:0] line;
    logic [31:0]     f0;
    logic [31:0]     f1;
    logic [31:0]     f2;
    ok = 1'b0;
    fd = $fopen(DATA_FILE, "r");
    if (fd != 0) begin
      ok = 1'b1;
      while (!$feof(fd)) begin
        line = '0;
        code = $fgets(line, fd);
        if (code > 0) begin
          if ($sscanf(line, "L %h %h", f0, f1) == 2) begin
            img_adr.push_back(f0);
            img_wrd.push_back(f1);
          end else if ($sscanf(line, "R %h %h %h", f0, f1, f2) == 3) begin
            exp_pc.push_back(f0);
            exp_rd.push_back(f1[4:0]);
            exp_wdt.push_back(f2);
          end
        end
      end
      $fclose(fd);
    end
  endtask

  // one full word per cycle, core still in reset
  task automatic load_program();
    for (int i = 0; i < img_adr.size(); i++) begin
      @(posedge bus_if);
      ldr_req.vld <= 1'b1;
      ldr_req.wen <= 1'b1;
      ldr_req.adr <= img_adr[i];
      ldr_req.ben <= '1;
      ldr_req.wdt <= img_wrd[i];
    end
    @(posedge bus_if);
    ldr_req <= '0;
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // retire monitor
  ////////////////////////////////////////////////////////////////////////////

  task automatic compare_value(input string name, input logic [31:0] exp_val,
                               input logic [31:0] act_val);
    if (act_val !== exp_val) begin
      $display("[ERROR] %s: expected %h, actual %h", name, exp_val, act_val);
      mismatch_cnt++;
    end
  endtask

  // retire is stable away from the rising edge
  always @(negedge bus_if) begin
    if (!rst && retire.vld) begin
      if (ret_cnt >= exp_pc.size()) begin
        $display("unexpected retire at pc %h after the last expected one", retire.pc);
        other_cnt++;
      end else begin
        compare_value($sformatf("retire_%0d.pc", ret_cnt), exp_pc[ret_cnt], retire.pc);
        compare_value($sformatf("retire_%0d.rd", ret_cnt), {27'd0, exp_rd[ret_cnt]},
                      {27'd0, retire.rd});
        compare_value($sformatf("retire_%0d.wdt", ret_cnt), exp_wdt[ret_cnt], retire.wdt);
      end
      ret_cnt++;
    end
  end

  ////////////////////////////////////////////////////////////////////////////
  // watchdog
  ////////////////////////////////////////////////////////////////////////////

  // four cycles per expected retire plus slack
  initial begin : watchdog
    int limit;
    wait (run_started);
    limit = exp_pc.size() * 4 + 50;
    repeat (limit) @(posedge bus_if);
    $display("timeout: the core did not halt within %0d cycles", limit);
    other_cnt++;
    $display("%0d value errors, %0d other errors", mismatch_cnt, other_cnt);
    $display("Errors found");
    $finish;
  end

  ////////////////////////////////////////////////////////////////////////////
  // main sequence
  ////////////////////////////////////////////////////////////////////////////

  initial begin : main
    bit ok;
    rst          = 1'b1;
    ldr_req      = '0;
    mismatch_cnt = 0;
    other_cnt    = 0;
    ret_cnt      = 0;
    run_started  = 1'b0;
    read_testdata(ok);
    if (!ok) begin
      $display("cannot open the test data file %s", DATA_FILE);
      $display("0 value errors, 1 other errors");
      $display("Errors found");
      $finish;
    end else begin
      load_program();
      // eight reset cycles once the image is in
      repeat (RST_CYCLES) @(posedge bus_if);
      rst <= 1'b0;
      run_started = 1'b1;
      while (halted !== 1'b1) @(negedge bus_if);
      // halted must hold with no further retire
      for (int c = 0; c < TAIL_CYCLES; c++) begin
        @(negedge bus_if);
        if (halted !== 1'b1) begin
          $display("halted dropped %0d cycles after the halt", c);
          other_cnt++;
        end
      end
      @(posedge bus_if);
      if (exp_pc.size() == 0) begin
        $display("the test data file holds no expected retires");
        other_cnt++;
      end
      if (ret_cnt != exp_pc.size()) begin
        $display("saw %0d retires but expected %0d", ret_cnt, exp_pc.size());
        other_cnt++;
      end
      $display("%0d value errors, %0d other errors", mismatch_cnt, other_cnt);
      if (mismatch_cnt == 0 && other_cnt == 0) begin
        $display("No errors");
      end else begin
        $display("Errors found");
      end
      $finish;
    end
  end

endmodule

/* compile.f */
+incdir+include
rtl/r5_isa_pkg.sv
rtl/r5_bus_pkg.sv
rtl/r5_mem.sv
rtl/r5_decode.sv
rtl/r5_execute.sv
rtl/r5_result.sv
rtl/r5_sys.sv
tests/r5_sys_tb.sv

/* Makefile */
# Verilator build and run of the r5 system testbench
# any variable below can be overridden on the command line

VERILATOR ?= verilator
TOP       ?= r5_sys_tb
FILELIST  ?= compile.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= No errors
VFLAGS    ?= --binary --timing --timescale 1ns/1ps -j 0

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(OBJ_DIR) -f $(FILELIST)

# the pass message in the log decides the exit status
run: compile
	./$(OBJ_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* tests/r5_testdata.txt */
# L lines hold one loader write as hex address then hex word
# R lines hold one expected retire as hex pc then rd then written value
# program
L 00 123450B7 # lui  x1, 0x12345
L 04 67800113 # addi x2, x0, 0x678
L 08 002081B3 # add  x3, x1, x2
L 0C FFB00213 # addi x4, x0, -5
L 10 002222B3 # slt  x5, x4, x2
L 14 FFF12313 # slti x6, x2, -1
L 18 403103B3 # sub  x7, x2, x3
L 1C 0041C433 # xor  x8, x3, x4
L 20 0020E4B3 # or   x9, x1, x2
L 24 0F01F513 # andi x10, x3, 0xf0
L 28 0FF14593 # xori x11, x2, 0xff
L 2C 70056613 # ori  x12, x10, 0x700
L 30 0083F6B3 # and  x13, x7, x8
L 34 00108013 # addi x0, x1, 1
L 38 00200733 # add  x14, x0, x2
L 3C 10002783 # lw   x15, 0x100(x0)
L 40 10302223 # sw   x3, 0x104(x0)
L 44 10402803 # lw   x16, 0x104(x0)
L 48 00918463 # beq  x3, x9, +8
L 4C 0BD00893 # addi x17, x0, 0xbd (skipped)
L 50 00919463 # bne  x3, x9, +8
L 54 00C0096F # jal  x18, +12
L 58 00100993 # addi x19, x0, 1 (skipped)
L 5C 00200993 # addi x19, x0, 2 (skipped)
L 60 00F90A33 # add  x20, x18, x15
L 64 00100073 # ebreak
L 68 0EE00A93 # addi x21, x0, 0xee (never reached)
# data word for the first load
L 100 CAFEF00D
# alu operations
R 00 01 12345000
R 04 02 00000678
R 08 03 12345678
R 0C 04 FFFFFFFB
R 10 05 00000001
R 14 06 00000000
R 18 07 EDCBB000
R 1C 08 EDCBA983
R 20 09 12345678
R 24 0A 00000070
R 28 0B 00000687
R 2C 0C 00000770
R 30 0D EDCBA000
# writes to x0 are dropped
R 34 00 00000000
R 38 0E 00000678
# loads and stores
R 3C 0F CAFEF00D
R 40 00 00000000
R 44 10 12345678
# branches and jump
R 48 00 00000000
R 50 00 00000000
R 54 12 00000058
R 60 14 CAFEF065
# halt
R 64 00 00000000
